/* rtl/bp_pkg.sv */
package bp_pkg;

    // byte address for pc, targets and predictions
    typedef logic [31:0] addr_t;

    // raw instruction word
    typedef logic [31:0] instr_t;

    // register operand value
    typedef logic [31:0] word_t;

    // widest entry identifier the predictor supports
    localparam int MAX_ID_BITS = 12;

    // entry identifier, zero extended when num_bits is below the max
    typedef logic [MAX_ID_BITS-1:0] entry_id_t;

    // coarse instruction class used by prediction and resolution
    typedef enum logic [3:0] {
        IR_OTHER   = 4'd0,
        IR_JAL     = 4'd1,
        IR_JALR    = 4'd2,
        IR_BRANCH  = 4'd3,
        IR_ILLEGAL = 4'd4
    } ir_class_t;

    // control transfer opcodes
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // remaining rv32i base opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_FENCE  = 7'b0001111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

endpackage

/* rtl/ir_class_decode.sv */
`timescale 1ns/1ns

module ir_class_decode (
    input  bp_pkg::instr_t    instr,
    output bp_pkg::ir_class_t ir_class
);

    import bp_pkg::*;

    // opcode and funct3 fields of the word
    logic [6:0] opcode;
    logic [2:0] funct3;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    always_comb begin
        case (opcode)
            OPC_JAL: begin
                ir_class = IR_JAL;
            end
            // jalr only defines funct3 of zero
            OPC_JALR: begin
                ir_class = (funct3 == 3'b000) ? IR_JALR : IR_ILLEGAL;
            end
            // funct3 2 and 3 are unused encodings for branches
            OPC_BRANCH: begin
                if (funct3 == 3'b010 || funct3 == 3'b011) begin
                    ir_class = IR_ILLEGAL;
                end else begin
                    ir_class = IR_BRANCH;
                end
            end
            // everything else the base isa knows about is not a jump
            OPC_LUI, OPC_AUIPC, OPC_LOAD, OPC_STORE,
            OPC_OP_IMM, OPC_OP, OPC_FENCE, OPC_SYSTEM: begin
                ir_class = IR_OTHER;
            end
            default: begin
                ir_class = IR_ILLEGAL;
            end
        endcase
    end

endmodule

/* rtl/jump_predictor.sv */
`timescale 1ns/1ns

module jump_predictor #(
    parameter int num_bits = 12
) (
    input  logic              clk,
    input  logic              rst_n,
    // read side, fetch stage
    input  bp_pkg::addr_t     fetch_pc,
    input  bp_pkg::ir_class_t fetch_class,
    // write side, from the resolver
    input  logic              upd_en,
    input  bp_pkg::addr_t     upd_pc,
    input  logic              upd_taken,
    input  bp_pkg::addr_t     upd_target,
    // prediction for fetch_pc
    output logic              pred_taken,
    output bp_pkg::addr_t     pred_addr
);

    import bp_pkg::*;

    // one entry per identifier, depth derived from the id width
    localparam int DEPTH = 2 ** num_bits;

    // target and state arrays, no reset
    addr_t target_mem [DEPTH];
    logic  state_mem  [DEPTH];

    // set by the first write to an entry, cleared by reset
    logic [DEPTH-1:0] init_vec;

    // entry id is the user/machine bit joined with the word index
    // pcs that differ only above bit num_bits alias onto one entry
    function automatic entry_id_t entry_id(input addr_t pc);
        entry_id_t id;
        id = '0;
        id[num_bits-1:0] = {pc[28], pc[num_bits:2]};
        return id;
    endfunction

    entry_id_t rd_id;
    entry_id_t wr_id;

    assign rd_id = entry_id(fetch_pc);
    assign wr_id = entry_id(upd_pc);

    // asynchronous read
    logic  rd_init;
    logic  rd_state;
    addr_t rd_target;
    addr_t pc_plus4;
    logic  is_jump;

    assign rd_init   = init_vec[rd_id[num_bits-1:0]];
    assign rd_state  = state_mem[rd_id[num_bits-1:0]];
    assign rd_target = target_mem[rd_id[num_bits-1:0]];
    assign pc_plus4  = fetch_pc + 32'd4;

    // only control transfers may follow the table
    assign is_jump = (fetch_class == IR_JAL) ||
                     (fetch_class == IR_JALR) ||
                     (fetch_class == IR_BRANCH);

    // taken only when the entry was written and says take
    assign pred_taken = is_jump && rd_init && rd_state;
    assign pred_addr  = pred_taken ? rd_target : pc_plus4;

    // payload write on the rising edge
    always_ff @(posedge clk) begin
        if (upd_en) begin
            target_mem[wr_id[num_bits-1:0]] <= upd_target;
            state_mem[wr_id[num_bits-1:0]]  <= upd_taken;
        end
    end

    // valid bits, the only state reset touches
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            init_vec <= '0;
        end else if (upd_en) begin
            init_vec[wr_id[num_bits-1:0]] <= 1'b1;
        end
    end

endmodule

/* rtl/fetch_pc.sv */
`timescale 1ns/1ns

module fetch_pc #(
    parameter bp_pkg::addr_t reset_pc = 32'h0000_0000
) (
    input  logic          clk,
    input  logic          rst_n,
    // advance strobe from the outside
    input  logic          fetch_valid,
    // next address guess from the predictor
    input  bp_pkg::addr_t pred_addr,
    // misprediction report from the resolver
    input  logic          redirect,
    input  bp_pkg::addr_t redirect_pc,
    output bp_pkg::addr_t pc
);

    import bp_pkg::*;

    // next value of the counter
    addr_t pc_next;

    // redirect wins over a normal advance
    always_comb begin
        if (redirect) begin
            pc_next = redirect_pc;
        end else if (fetch_valid) begin
            pc_next = pred_addr;
        end else begin
            // no strobe, hold the current address
            pc_next = pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= reset_pc;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

/* rtl/jump_resolver.sv */
`timescale 1ns/1ns

module jump_resolver (
    input  logic              ex_valid,
    input  bp_pkg::addr_t     ex_pc,
    input  bp_pkg::instr_t    ex_instr,
    input  bp_pkg::ir_class_t ex_class,
    input  bp_pkg::word_t     rs1_val,
    input  bp_pkg::word_t     rs2_val,
    // prediction the instruction got at fetch
    input  logic              ex_pred_taken,
    input  bp_pkg::addr_t     ex_pred_addr,
    // fetch redirect
    output logic              redirect,
    output bp_pkg::addr_t     redirect_pc,
    // predictor write port
    output logic              upd_en,
    output bp_pkg::addr_t     upd_pc,
    output logic              upd_taken,
    output bp_pkg::addr_t     upd_target
);

    import bp_pkg::*;

    // sign extended immediates
    word_t imm_i;
    word_t imm_b;
    word_t imm_j;

    assign imm_i = {{20{ex_instr[31]}}, ex_instr[31:20]};
    assign imm_b = {{19{ex_instr[31]}}, ex_instr[31], ex_instr[7],
                    ex_instr[30:25], ex_instr[11:8], 1'b0};
    assign imm_j = {{11{ex_instr[31]}}, ex_instr[31], ex_instr[19:12],
                    ex_instr[20], ex_instr[30:21], 1'b0};

    // branch condition from funct3
    logic cond;

    always_comb begin
        case (ex_instr[14:12])
            3'b000:  cond = (rs1_val == rs2_val);
            3'b001:  cond = (rs1_val != rs2_val);
            3'b100:  cond = ($signed(rs1_val) < $signed(rs2_val));
            3'b101:  cond = ($signed(rs1_val) >= $signed(rs2_val));
            3'b110:  cond = (rs1_val < rs2_val);
            3'b111:  cond = (rs1_val >= rs2_val);
            default: cond = 1'b0;
        endcase
    end

    // jalr sum before the lsb is dropped
    addr_t jalr_sum;
    addr_t target;
    logic  taken;
    logic  is_jump;
    logic  mispredict;

    assign jalr_sum = rs1_val + imm_i;

    // jumps always go, branches follow the compare
    always_comb begin
        case (ex_class)
            IR_JAL: begin
                taken  = 1'b1;
                target = ex_pc + imm_j;
            end
            IR_JALR: begin
                taken  = 1'b1;
                target = {jalr_sum[31:1], 1'b0};
            end
            IR_BRANCH: begin
                taken  = cond;
                target = ex_pc + imm_b;
            end
            default: begin
                taken  = 1'b0;
                target = ex_pc + imm_b;
            end
        endcase
    end

    assign is_jump = (ex_class == IR_JAL) ||
                     (ex_class == IR_JALR) ||
                     (ex_class == IR_BRANCH);

    // wrong direction, or right direction with a stale target
    assign mispredict = ex_valid && is_jump &&
                        ((taken != ex_pred_taken) ||
                         (taken && (target != ex_pred_addr)));

    assign redirect    = mispredict;
    assign redirect_pc = taken ? target : (ex_pc + 32'd4);

    // the table is rewritten only when it was wrong
    assign upd_en     = mispredict;
    assign upd_pc     = ex_pc;
    assign upd_taken  = taken;
    assign upd_target = target;

endmodule

/* rtl/predict_top.sv */
`timescale 1ns/1ns

module predict_top #(
    parameter int            num_bits = 12,
    parameter bp_pkg::addr_t reset_pc = 32'h0000_0000
) (
    input  logic           clk,
    input  logic           rst_n,
    // fetch side
    input  bp_pkg::instr_t fetch_instr,
    input  logic           fetch_valid,
    output bp_pkg::addr_t  fetch_pc,
    output logic           pred_taken,
    output bp_pkg::addr_t  pred_addr,
    // execute side
    input  logic           ex_valid,
    input  bp_pkg::addr_t  ex_pc,
    input  bp_pkg::instr_t ex_instr,
    input  bp_pkg::word_t  rs1_val,
    input  bp_pkg::word_t  rs2_val,
    input  logic           ex_pred_taken,
    input  bp_pkg::addr_t  ex_pred_addr,
    output logic           redirect,
    output bp_pkg::addr_t  redirect_pc
);

    import bp_pkg::*;

    // classes of the two instruction words
    ir_class_t fetch_class;
    ir_class_t ex_class;

    // resolver to predictor write port
    logic  upd_en;
    addr_t upd_pc;
    logic  upd_taken;
    addr_t upd_target;

    ir_class_decode if_dec0 (
        .instr    (fetch_instr),
        .ir_class (fetch_class)
    );

    ir_class_decode ex_dec0 (
        .instr    (ex_instr),
        .ir_class (ex_class)
    );

    jump_predictor #(
        .num_bits (num_bits)
    ) pred0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_pc    (fetch_pc),
        .fetch_class (fetch_class),
        .upd_en      (upd_en),
        .upd_pc      (upd_pc),
        .upd_taken   (upd_taken),
        .upd_target  (upd_target),
        .pred_taken  (pred_taken),
        .pred_addr   (pred_addr)
    );

    // redirect lands in fetch_pc on the next edge
    fetch_pc #(
        .reset_pc (reset_pc)
    ) pc0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .pred_addr   (pred_addr),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .pc          (fetch_pc)
    );

    jump_resolver res0 (
        .ex_valid      (ex_valid),
        .ex_pc         (ex_pc),
        .ex_instr      (ex_instr),
        .ex_class      (ex_class),
        .rs1_val       (rs1_val),
        .rs2_val       (rs2_val),
        .ex_pred_taken (ex_pred_taken),
        .ex_pred_addr  (ex_pred_addr),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .upd_en        (upd_en),
        .upd_pc        (upd_pc),
        .upd_taken     (upd_taken),
        .upd_target    (upd_target)
    );

endmodule

/* tb/tb_util.svh */
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

// xorshift32 step on the shared generator state
function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

// j-type word, imm is the byte offset
function automatic instr_t build_jal(input logic [4:0] rd, input word_t imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
endfunction

// i-type jalr, funct3 left open so illegal forms can be built
function automatic instr_t build_jalr(input logic [4:0] rd, input logic [4:0] rs1,
                                      input logic [2:0] f3, input word_t imm);
    return {imm[11:0], rs1, f3, rd, OPC_JALR};
endfunction

// b-type word comparing x1 with x2
function automatic instr_t build_branch(input logic [2:0] f3, input word_t imm);
    return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], OPC_BRANCH};
endfunction

task automatic check_addr(input addr_t got, input addr_t exp, input string what);
    if (got !== exp) begin
        $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        $display("Result: FAILED");
        $fatal(1, "stopping on first wrong address");
    end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        $display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
        $display("Result: FAILED");
        $fatal(1, "stopping on first wrong bit");
    end
endtask

`endif

/* tb/tb_predict.sv */
`timescale 1ns/1ns

module tb_predict;

    import bp_pkg::*;

    localparam int    NB         = 6;
    localparam int    DEPTH      = 2 ** NB;
    localparam addr_t RESET_PC   = 32'h0000_0000;
    localparam int    NUM_CYCLES = 2000;
    // stimulus plus reset plus a quarter for slack
    localparam int    TIMEOUT    = NUM_CYCLES + NUM_CYCLES / 4;

    // branch compares of the slots, indexed by slot bits {3, 1:0}
    localparam logic [7:0][2:0] BR_F3 = {3'b000, 3'b111, 3'b110, 3'b101,
                                          3'b000, 3'b100, 3'b001, 3'b000};

    logic   clk;
    logic   rst_n;
    instr_t fetch_instr;
    logic   fetch_valid;
    addr_t  fetch_pc;
    logic   pred_taken;
    addr_t  pred_addr;
    logic   ex_valid;
    addr_t  ex_pc;
    instr_t ex_instr;
    word_t  rs1_val;
    word_t  rs2_val;
    logic   ex_pred_taken;
    addr_t  ex_pred_addr;
    logic   redirect;
    addr_t  redirect_pc;

    logic [31:0] rng_state;
    int          cycle_cnt;

    // model table, same shape as the predictor
    logic  m_init   [DEPTH];
    logic  m_state  [DEPTH];
    addr_t m_target [DEPTH];

    // fixed program slots for the execute side
    addr_t      slot_pc    [16];
    instr_t     slot_instr [16];
    ir_class_t  slot_cls   [16];
    logic [2:0] slot_f3    [16];
    word_t      slot_imm   [16];
    word_t      slot_rs1   [16];

    // what the model knows about the words it drove
    ir_class_t  fetch_cls;
    ir_class_t  ex_cls;
    logic [2:0] ex_f3;
    word_t      ex_imm;

    // expected fetch pc and the pending table write
    addr_t exp_pc;
    addr_t exp_next;
    logic  wr_pend;
    addr_t wr_pc;
    logic  wr_taken;
    addr_t wr_target;

    `include "tb_util.svh"

    predict_top #(
        .num_bits (NB),
        .reset_pc (RESET_PC)
    ) dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .fetch_instr   (fetch_instr),
        .fetch_valid   (fetch_valid),
        .fetch_pc      (fetch_pc),
        .pred_taken    (pred_taken),
        .pred_addr     (pred_addr),
        .ex_valid      (ex_valid),
        .ex_pc         (ex_pc),
        .ex_instr      (ex_instr),
        .rs1_val       (rs1_val),
        .rs2_val       (rs2_val),
        .ex_pred_taken (ex_pred_taken),
        .ex_pred_addr  (ex_pred_addr),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // user/machine bit on top of the word index
    function automatic int entry_of(input addr_t pc);
        return {pc[28], pc[NB:2]};
    endfunction

    function automatic logic is_jump(input ir_class_t cls);
        return (cls == IR_JAL) || (cls == IR_JALR) || (cls == IR_BRANCH);
    endfunction

    // signed less-than from the sign bits, unsigned compare when signs agree
    function automatic logic branch_cond(input logic [2:0] f3, input word_t a, input word_t b);
        logic slt;
        slt = (a[31] != b[31]) ? a[31] : (a < b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return slt;
            3'b101:  return !slt;
            3'b110:  return a < b;
            3'b111:  return !(a < b);
            default: return 1'b0;
        endcase
    endfunction

    task automatic model_predict(input addr_t pc, input ir_class_t cls,
                                 output logic taken, output addr_t addr);
        int id;
        id = entry_of(pc);
        taken = is_jump(cls) && m_init[id] && m_state[id];
        addr = taken ? m_target[id] : pc + 32'd4;
    endtask

    // word of the class picked by sel[2:0], branch compare from sel[5:3]
    // immediates and the remaining fields are random
    task automatic make_instr(input logic [5:0] sel, output instr_t w, output ir_class_t c,
                              output logic [2:0] f3, output word_t imm);
        logic [31:0] r;
        r = next_rand();
        f3 = 3'b000;
        imm = '0;
        case (sel[2:0])
            3'd0, 3'd1: begin
                c = IR_OTHER;
                w = {r[31:7], OPC_OP_IMM};
            end
            3'd2: begin
                c = IR_JAL;
                imm = {{11{r[30]}}, r[30:11], 1'b0};
                w = build_jal(5'd1, imm);
            end
            3'd3: begin
                c = IR_JALR;
                imm = {{20{r[31]}}, r[31:20]};
                w = build_jalr(5'd1, 5'd5, 3'b000, imm);
            end
            3'd4, 3'd5, 3'd6: begin
                c = IR_BRANCH;
                f3 = sel[5:3];
                // funct3 2 and 3 are reserved, fold onto the unsigned compares
                if (f3[2:1] == 2'b01) begin
                    f3[2] = 1'b1;
                end
                imm = {{19{r[31]}}, r[31:20], 1'b0};
                w = build_branch(f3, imm);
            end
            default: begin
                c = IR_ILLEGAL;
                if (r[8]) begin
                    w = build_jalr(5'd1, 5'd5, {r[10:9], 1'b1}, '0);
                end else begin
                    w = build_branch({2'b01, r[9]}, '0);
                end
            end
        endcase
    endtask

    // run limit, counted from time zero
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("Result: FAILED");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    initial begin
        instr_t      f_w;
        logic [2:0]  f_f3;
        word_t       f_imm;
        logic [31:0] r;
        logic [3:0]  s;
        word_t       a;
        word_t       b;
        logic        pt;
        addr_t       pa;
        logic        taken;
        addr_t       target;
        addr_t       rpc;
        logic        mis;
        int          id;

        rng_state     = 32'h563;
        cycle_cnt     = 0;
        rst_n         = 1'b0;
        fetch_instr   = '0;
        fetch_valid   = 1'b0;
        ex_valid      = 1'b0;
        ex_pc         = '0;
        ex_instr      = '0;
        rs1_val       = '0;
        rs2_val       = '0;
        ex_pred_taken = 1'b0;
        ex_pred_addr  = '0;
        fetch_cls     = IR_OTHER;
        for (int i = 0; i < DEPTH; i++) begin
            m_init[i]   = 1'b0;
            m_state[i]  = 1'b0;
            m_target[i] = '0;
        end

        // slot bits: [1:0] word index, [2] pc bit 28, [3] pc bit 9 which aliases
        for (int i = 0; i < 16; i++) begin
            s = i[3:0];
            slot_pc[i] = {3'b000, s[2], 15'd0, 1'b1, 2'b00, s[3], 5'd0, s[1:0], 2'b00};
            // class follows the slot index so every class and all six compares are present
            make_instr({BR_F3[{s[3], s[1:0]}], s[2:0]}, f_w, fetch_cls, f_f3, f_imm);
            slot_instr[i] = f_w;
            slot_cls[i]   = fetch_cls;
            slot_f3[i]    = f_f3;
            slot_imm[i]   = f_imm;
        end
        // jalr base chosen so the target lands on another slot
        for (int i = 0; i < 16; i++) begin
            r = next_rand();
            slot_rs1[i] = slot_pc[r[3:0]] - slot_imm[i];
        end

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        exp_next = RESET_PC;
        wr_pend  = 1'b0;

        repeat (NUM_CYCLES) begin
            @(posedge clk);
            // mirror what the edge just did to the dut
            exp_pc = exp_next;
            if (wr_pend) begin
                id = entry_of(wr_pc);
                m_init[id]   = 1'b1;
                m_state[id]  = wr_taken;
                m_target[id] = wr_target;
            end

            r = next_rand();
            make_instr(r[5:0], f_w, fetch_cls, f_f3, f_imm);
            r = next_rand();
            s = r[3:0];
            ex_cls = slot_cls[s];
            ex_f3  = slot_f3[s];
            ex_imm = slot_imm[s];
            a = r[4] ? slot_rs1[s] : next_rand();
            b = (r[6:5] == 2'b00) ? a : next_rand();
            // prediction the pipeline would have carried, sometimes spoiled
            model_predict(slot_pc[s], ex_cls, pt, pa);
            if (r[9:7] == 3'd0) begin
                pt = !pt;
            end
            if (r[12:10] == 3'd0) begin
                pa = pa + 32'd8;
            end

            fetch_instr   <= f_w;
            fetch_valid   <= (r[14:13] != 2'b00);
            ex_valid      <= (r[16:15] != 2'b00);
            ex_pc         <= slot_pc[s];
            ex_instr      <= slot_instr[s];
            rs1_val       <= a;
            rs2_val       <= b;
            ex_pred_taken <= pt;
            ex_pred_addr  <= pa;

            @(negedge clk);
            check_addr(fetch_pc, exp_pc, "fetch_pc");
            model_predict(exp_pc, fetch_cls, pt, pa);
            check_bit(pred_taken, pt, "pred_taken");
            check_addr(pred_addr, pa, "pred_addr");

            // resolve the ex instruction from the class and fields it was built with
            taken  = 1'b0;
            target = ex_pc + ex_imm;
            if (ex_cls == IR_JAL) begin
                taken = 1'b1;
            end else if (ex_cls == IR_JALR) begin
                taken  = 1'b1;
                target = (rs1_val + ex_imm) & ~32'd1;
            end else if (ex_cls == IR_BRANCH) begin
                taken = branch_cond(ex_f3, rs1_val, rs2_val);
            end
            mis = ex_valid && is_jump(ex_cls) &&
                  ((taken != ex_pred_taken) || (taken && (target != ex_pred_addr)));
            rpc = taken ? target : ex_pc + 32'd4;
            check_bit(redirect, mis, "redirect");
            if (mis) begin
                check_addr(redirect_pc, rpc, "redirect_pc");
            end

            wr_pend   = mis;
            wr_pc     = ex_pc;
            wr_taken  = taken;
            wr_target = target;
            if (mis) begin
                exp_next = rpc;
            end else if (fetch_valid) begin
                exp_next = pa;
            end else begin
                exp_next = exp_pc;
            end
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

/* all.f */
+incdir+tb
rtl/bp_pkg.sv
rtl/ir_class_decode.sv
rtl/jump_predictor.sv
rtl/fetch_pc.sv
rtl/jump_resolver.sv
rtl/predict_top.sv
tb/tb_predict.sv
